/* sim.f */
+incdir+source
source/tracker_pkg.sv
source/id_generator.sv
source/issue_unit.sv
source/exec_unit.sv
source/completion_arbiter.sv
source/inflight_tracker_top.sv
testbench/tb_inflight_tracker.sv

/* source/completion_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tracker_defines.svh"

module completion_arbiter
    import tracker_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`TRK_NUM_UNITS-1:0] ready,
    input  result_t                   heads [`TRK_NUM_UNITS],
    output logic [`TRK_NUM_UNITS-1:0] pop,
    output logic                      complete,
    output id_t                       complete_id,
    output logic                      result_valid,
    output result_t                   result
);

    // Index of the granted unit
    logic [`TRK_UNIT_W-1:0] sel;

    // Descending scan so the lowest ready index is the last one kept
    always_comb begin
        sel = '0;
        for (int u = `TRK_NUM_UNITS - 1; u >= 0; u--) begin
            if (ready[u]) begin
                sel = u[`TRK_UNIT_W-1:0];
            end
        end
    end

    // Pop and ID return happen in the grant cycle
    always_comb begin
        pop = '0;
        pop[sel] = |ready;
    end

    assign complete = |ready;
    assign complete_id = heads[sel].id;

    // Output pulse one cycle after the pop
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= complete;
        end
    end

    // Chosen head leaves together with result_valid
    always_ff @(posedge clk) begin
        result <= heads[sel];
    end

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tracker_defines.svh"

module exec_unit
    import tracker_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    input  logic      pop,
    output logic      ready,
    output result_t   head
);

    // Pipeline stages
    logic [`TRK_EXEC_LATENCY-1:0] stage_valid;
    result_t                      stage_data [`TRK_EXEC_LATENCY];
    logic [`TRK_DATA_W-1:0]       exec_value;

    // Result queue
    result_t                      queue_mem [`TRK_NUM_IDS];
    id_t                          wr_ptr;
    id_t                          rd_ptr;
    logic [`TRK_ID_W:0]           count;
    logic                         push;
    logic                         full;

    // Whole operation done ahead of the first stage register
    always_comb begin
        case (dispatch.op)
            op_add:  exec_value = dispatch.a + dispatch.b;
            op_sub:  exec_value = dispatch.a - dispatch.b;
            op_xor:  exec_value = dispatch.a ^ dispatch.b;
            op_shl:  exec_value = dispatch.a << dispatch.b[$clog2(`TRK_DATA_W)-1:0];
            default: exec_value = '0;
        endcase
    end

    // Valid bits shift every cycle without a stall
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= dispatch_valid;
            for (int s = 1; s < `TRK_EXEC_LATENCY; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    // Value and ID ride along with the valid bits
    always_ff @(posedge clk) begin
        stage_data[0].id <= dispatch.id;
        stage_data[0].value <= exec_value;
        for (int s = 1; s < `TRK_EXEC_LATENCY; s++) begin
            stage_data[s] <= stage_data[s-1];
        end
    end

    // Last stage drops straight into the queue
    assign push = stage_valid[`TRK_EXEC_LATENCY-1];
    assign full = (count == (`TRK_ID_W+1)'(`TRK_NUM_IDS));

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= stage_data[`TRK_EXEC_LATENCY-1];
        end
    end

    // Pointers are ID wide so they wrap at the queue depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign ready = (count != '0);
    assign head = queue_mem[rd_ptr];

    // ID count bounds the queue contents
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("exec_unit: push into a full result queue");

    // Arbiter only pops units that report ready
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> ready)
        else $error("exec_unit: pop from an empty result queue");

endmodule

`default_nettype wire

/* source/id_generator.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tracker_defines.svh"

module id_generator
    import tracker_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic complete,
    input  id_t  complete_id,
    output id_t  issue_id,
    output logic id_available
);

    // One bit per ID, high while the ID is in flight
    logic [`TRK_NUM_IDS-1:0] in_use;
    logic [`TRK_NUM_IDS-1:0] set_mask;
    logic [`TRK_NUM_IDS-1:0] clear_mask;

    // Issue sets the granted ID
    // Completion clears the returned ID
    always_comb begin
        set_mask = '0;
        clear_mask = '0;
        set_mask[issue_id] = advance;
        clear_mask[complete_id] = complete;
    end

    // Set applied after clear so a reissued ID stays in use
    always_ff @(posedge clk) begin
        if (rst) begin
            in_use <= '0;
        end else begin
            in_use <= (in_use & ~clear_mask) | set_mask;
        end
    end

    // Ascending scan so the highest free ID is the last one kept
    // With nothing free the completing ID is handed straight back
    always_comb begin
        issue_id = complete_id;
        for (int i = 0; i < `TRK_NUM_IDS; i++) begin
            if (!in_use[i]) begin
                issue_id = id_t'(i);
            end
        end
    end

    // Free bit exists or one is being returned this cycle
    assign id_available = complete | ~(&in_use);

    // Issue side must respect availability
    advance_needs_id: assert property (@(posedge clk) disable iff (rst)
        advance |-> id_available)
        else $error("id_generator: advance without a free ID");

    // Arbiter may only return an ID that was handed out
    complete_in_use: assert property (@(posedge clk) disable iff (rst)
        complete |-> in_use[complete_id])
        else $error("id_generator: completion of an ID not in use");

endmodule

`default_nettype wire

/* source/inflight_tracker_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tracker_defines.svh"

module inflight_tracker_top
    import tracker_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    instr_valid,
    input  instr_t  instr,
    output logic    accept,
    output id_t     issue_id,
    output logic    result_valid,
    output result_t result
);

    // ID handshake between generator, issue and arbiter
    logic                      id_available;
    logic                      advance;
    logic                      complete;
    id_t                       complete_id;

    // Issue to units
    logic [`TRK_NUM_UNITS-1:0] dispatch_valid;
    dispatch_t                 dispatch;

    // Units to arbiter
    logic [`TRK_NUM_UNITS-1:0] unit_ready;
    logic [`TRK_NUM_UNITS-1:0] unit_pop;
    result_t                   unit_heads [`TRK_NUM_UNITS];

    id_generator id_generator_i (
        .clk          (clk),
        .rst          (rst),
        .advance      (advance),
        .complete     (complete),
        .complete_id  (complete_id),
        .issue_id     (issue_id),
        .id_available (id_available)
    );

    issue_unit issue_unit_i (
        .instr_valid    (instr_valid),
        .instr          (instr),
        .id_available   (id_available),
        .issue_id       (issue_id),
        .accept         (accept),
        .advance        (advance),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch)
    );

    // One unit per strobe bit
    // All share the dispatch bus
    for (genvar u = 0; u < `TRK_NUM_UNITS; u++) begin : gen_units
        exec_unit exec_unit_i (
            .clk            (clk),
            .rst            (rst),
            .dispatch_valid (dispatch_valid[u]),
            .dispatch       (dispatch),
            .pop            (unit_pop[u]),
            .ready          (unit_ready[u]),
            .head           (unit_heads[u])
        );
    end

    completion_arbiter completion_arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .ready        (unit_ready),
        .heads        (unit_heads),
        .pop          (unit_pop),
        .complete     (complete),
        .complete_id  (complete_id),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

/* source/issue_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tracker_defines.svh"

module issue_unit
    import tracker_pkg::*;
(
    input  logic                      instr_valid,
    input  instr_t                    instr,
    input  logic                      id_available,
    input  id_t                       issue_id,
    output logic                      accept,
    output logic                      advance,
    output logic [`TRK_NUM_UNITS-1:0] dispatch_valid,
    output dispatch_t                 dispatch
);

    // Only stall point of the design
    // Instruction waits here until an ID frees up
    assign accept = instr_valid & id_available;

    // Granted ID is consumed on the same cycle as the accept
    assign advance = accept;

    // Unit select decoded to a one-hot strobe
    always_comb begin
        dispatch_valid = '0;
        dispatch_valid[instr.unit] = accept;
    end

    // Shared bus to all units
    // Only the strobed unit latches it
    always_comb begin
        dispatch.op = instr.op;
        dispatch.a = instr.a;
        dispatch.b = instr.b;
        dispatch.id = issue_id;
    end

endmodule

`default_nettype wire

/* source/tracker_defines.svh */
`ifndef TRACKER_DEFINES_SVH
`define TRACKER_DEFINES_SVH

// Number of in-flight IDs
// Also bounds the results waiting in any one unit queue
`define TRK_NUM_IDS 4
`define TRK_ID_W 2

// Execution units and the select field that names one
`define TRK_NUM_UNITS 2
`define TRK_UNIT_W 1

// Pipeline depth of every execution unit in cycles
`define TRK_EXEC_LATENCY 3

// Operand and result width
`define TRK_DATA_W 32

`endif

/* source/tracker_pkg.sv */
`default_nettype none
`include "tracker_defines.svh"

package tracker_pkg;

    // Arithmetic operations
    // op_shl shifts a left by the low bits of b
    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_xor,
        op_shl
    } op_e;

    // Tag carried by an instruction from issue to completion
    typedef logic [`TRK_ID_W-1:0] id_t;

    // Instruction as it arrives from outside
    typedef struct packed {
        op_e                    op;
        logic [`TRK_UNIT_W-1:0] unit;
        logic [`TRK_DATA_W-1:0] a;
        logic [`TRK_DATA_W-1:0] b;
    } instr_t;

    // Tagged instruction sent to the execution units
    typedef struct packed {
        op_e                    op;
        logic [`TRK_DATA_W-1:0] a;
        logic [`TRK_DATA_W-1:0] b;
        id_t                    id;
    } dispatch_t;

    // Computed value and the ID it belongs to
    typedef struct packed {
        id_t                    id;
        logic [`TRK_DATA_W-1:0] value;
    } result_t;

endpackage

`default_nettype wire

/* testbench/tb_inflight_tracker.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tracker_defines.svh"

module tb_inflight_tracker
    import tracker_pkg::*;
();

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 10;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          SAMPLE_DELAY = 2;
    localparam int          STALL_LIMIT  = 64;
    localparam int          DRAIN_LIMIT  = 200;
    localparam logic [31:0] SEED         = 32'h9d0e_4670;

    // One table row
    // The flag says whether instr_valid is raised
    typedef struct packed {
        logic   valid;
        instr_t instr;
    } row_t;

    logic    clk;
    logic    rst;
    logic    instr_valid;
    instr_t  instr;
    logic    accept;
    id_t     issue_id;
    logic    result_valid;
    result_t result;

    row_t                   table_q [$];
    logic [31:0]            rng_state;

    // ID model and scoreboard with one slot per ID
    logic [`TRK_NUM_IDS-1:0] in_use;
    logic [`TRK_DATA_W-1:0]  exp_value [`TRK_NUM_IDS];
    int                      issue_cycle [`TRK_NUM_IDS];

    // ID handed out again while its old result is still on the way
    logic                    reissue_pending;
    id_t                     reissue_id;
    logic [`TRK_DATA_W-1:0]  reissue_value;
    int                      reissue_cycle;

    // Stall with every ID taken means no pop, so no result next cycle
    logic                    expect_quiet;
    int                      cycle;

    inflight_tracker_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .accept       (accept),
        .issue_id     (issue_id),
        .result_valid (result_valid),
        .result       (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic end_in_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end_in_failure();
    endtask

    task automatic abort_with_error(input string what);
        $display("ERROR t=%0t %s", $time, what);
        end_in_failure();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Op rules; shl uses the low 5 bits of b
    function automatic logic [`TRK_DATA_W-1:0] expected_value(input instr_t i);
        case (i.op)
            op_add:  return i.a + i.b;
            op_sub:  return i.a - i.b;
            op_xor:  return i.a ^ i.b;
            op_shl:  return i.a << i.b[4:0];
            default: return '0;
        endcase
    endfunction

    // Search from the top so the first free ID found wins
    function automatic id_t highest_free(input logic [`TRK_NUM_IDS-1:0] used);
        id_t  pick;
        logic found;
        pick = '0;
        found = 1'b0;
        for (int i = `TRK_NUM_IDS - 1; i >= 0; i--) begin
            if (!used[i] && !found) begin
                pick = id_t'(i);
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    task automatic add_row(input logic valid, input op_e op, input logic [`TRK_UNIT_W-1:0] unit,
                           input logic [31:0] a, input logic [31:0] b);
        row_t r;
        r.valid = valid;
        r.instr.op = op;
        r.instr.unit = unit;
        r.instr.a = a;
        r.instr.b = b;
        table_q.push_back(r);
    endtask

    task automatic add_random_row(input logic valid);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        rng_state = xorshift32(rng_state);
        a = rng_state;
        rng_state = xorshift32(rng_state);
        b = rng_state;
        rng_state = xorshift32(rng_state);
        c = rng_state;
        add_row(valid, op_e'(c[1:0]), c[2], a, b);
    endtask

    task automatic build_table();
        add_row(1'b0, op_add, 1'b0, 32'h0, 32'h0);
        // Six edge-operand rows back to back so the IDs run out
        add_row(1'b1, op_add, 1'b0, 32'hffff_ffff, 32'h0000_0001);
        add_row(1'b1, op_sub, 1'b1, 32'h0000_0000, 32'h0000_0001);
        add_row(1'b1, op_xor, 1'b0, 32'haaaa_aaaa, 32'h5555_5555);
        add_row(1'b1, op_shl, 1'b1, 32'h0000_0001, 32'h0000_001f);
        add_row(1'b1, op_shl, 1'b0, 32'h1234_5678, 32'h0000_0023);
        add_row(1'b1, op_sub, 1'b1, 32'h8000_0000, 32'h0000_0001);
        add_row(1'b0, op_add, 1'b0, 32'h0, 32'h0);
        add_row(1'b0, op_add, 1'b0, 32'h0, 32'h0);
        add_row(1'b1, op_add, 1'b1, 32'h7fff_ffff, 32'h0000_0001);
        add_row(1'b0, op_add, 1'b0, 32'h0, 32'h0);
        add_row(1'b1, op_shl, 1'b0, 32'hdead_beef, 32'hffff_ffe0);
        // Long random burst then a sparse random tail
        for (int k = 0; k < 12; k++) begin
            add_random_row(1'b1);
        end
        add_row(1'b0, op_add, 1'b0, 32'h0, 32'h0);
        add_row(1'b0, op_add, 1'b0, 32'h0, 32'h0);
        for (int k = 0; k < 8; k++) begin
            add_random_row(k[0]);
        end
    endtask

    // Result of the pop in the previous cycle
    task automatic settle_result();
        id_t rid;
        if (expect_quiet) begin
            assert (!result_valid) else flag_mismatch("result_valid", 32'h0, result_valid);
            expect_quiet = 1'b0;
        end
        if (reissue_pending) begin
            assert (result_valid && result.id == reissue_id)
                else abort_with_error("reissued ID did not return in the next cycle");
        end
        if (result_valid) begin
            rid = result.id;
            assert (in_use[rid])
                else abort_with_error("result carries an ID that is not in flight");
            assert (result.value == exp_value[rid])
                else flag_mismatch("result.value", exp_value[rid], result.value);
            assert (cycle - issue_cycle[rid] >= `TRK_EXEC_LATENCY + 1)
                else abort_with_error("result returned sooner than the pipeline allows");
            if (reissue_pending && rid == reissue_id) begin
                // Old result gone so the new issue now owns the slot
                exp_value[rid] = reissue_value;
                issue_cycle[rid] = reissue_cycle;
                reissue_pending = 1'b0;
            end else begin
                in_use[rid] = 1'b0;
            end
        end
    endtask

    // Accept level and granted ID of the current cycle
    task automatic verify_issue();
        id_t exp_id;
        if (in_use != '1) begin
            assert (accept == instr_valid) else flag_mismatch("accept", instr_valid, accept);
            if (accept) begin
                exp_id = highest_free(in_use);
                assert (issue_id == exp_id) else flag_mismatch("issue_id", exp_id, issue_id);
                in_use[exp_id] = 1'b1;
                exp_value[exp_id] = expected_value(instr);
                issue_cycle[exp_id] = cycle;
            end
        end else begin
            assert (instr_valid || !accept) else flag_mismatch("accept", 32'h0, accept);
            if (accept) begin
                // Only a completing ID can be granted and it returns next cycle
                reissue_pending = 1'b1;
                reissue_id = issue_id;
                reissue_value = expected_value(instr);
                reissue_cycle = cycle;
            end else if (instr_valid) begin
                expect_quiet = 1'b1;
            end
        end
    endtask

    task automatic run_cycle(input row_t r);
        @(posedge clk);
        #DRIVE_DELAY;
        cycle++;
        instr_valid = r.valid;
        instr = r.instr;
        #SAMPLE_DELAY;
        settle_result();
        verify_issue();
    endtask

    initial begin
        row_t idle;
        int   row_idx;
        int   stall;
        int   drain;
        clk = 1'b0;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        idle = '0;
        rng_state = SEED;
        in_use = '0;
        reissue_pending = 1'b0;
        reissue_id = '0;
        reissue_value = '0;
        reissue_cycle = 0;
        expect_quiet = 1'b0;
        cycle = 0;
        for (int i = 0; i < `TRK_NUM_IDS; i++) begin
            exp_value[i] = '0;
            issue_cycle[i] = 0;
        end
        build_table();

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            assert (!result_valid) else flag_mismatch("result_valid", 32'h0, result_valid);
        end
        rst = 1'b0;

        // A stalled row is driven again until it is taken
        row_idx = 0;
        stall = 0;
        while (row_idx < table_q.size()) begin
            run_cycle(table_q[row_idx]);
            if (!table_q[row_idx].valid || accept) begin
                row_idx++;
                stall = 0;
            end else begin
                stall++;
                assert (stall < STALL_LIMIT)
                    else abort_with_error("instruction was never accepted");
            end
        end

        drain = 0;
        while (in_use != '0 || reissue_pending) begin
            run_cycle(idle);
            drain++;
            assert (drain < DRAIN_LIMIT)
                else abort_with_error("outstanding results did not return");
        end

        // Idle tail catches any stray result
        repeat (8) begin
            run_cycle(idle);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
